//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // fetch address and instruction word
    localparam int XLEN = 32;
    // only the low address bits reach the cache and memory
    localparam int ADDR_USED = 16;
    // byte offset inside one block
    localparam int OFFSET_BITS = 3;
    // memory data bus, also one cache line
    localparam int BLOCK_BITS = 64;
    // transaction tag on the memory port, 0 means nothing
    localparam int MEM_TAG_BITS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // memory commands
    ////////////////////////////////////////////////////////////////////////////

    localparam int CMD_BITS = 2;
    localparam logic [CMD_BITS-1:0] CMD_NONE = 2'd0;
    localparam logic [CMD_BITS-1:0] CMD_LOAD = 2'd1;

    ////////////////////////////////////////////////////////////////////////////
    // register byte offsets on the wishbone port
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [3:0] CSR_CTRL = 4'h0;
    localparam logic [3:0] CSR_HITS = 4'h4;
    localparam logic [3:0] CSR_MISSES = 4'h8;

    // one memory block
    // dword for fill and memory, inst[] picked by address bit 2 for fetch
    typedef union packed {
        logic [BLOCK_BITS-1:0] dword;
        logic [BLOCK_BITS/XLEN-1:0][XLEN-1:0] inst;
    } mem_block_u;

endpackage

`default_nettype wire

//--- src/icache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if #(
    parameter int NUM_LINES = 32
);
    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = icache_pkg::ADDR_USED - icache_pkg::OFFSET_BITS - IDX_BITS;

    // lookup side, combinational
    logic [IDX_BITS-1:0] index;
    logic [TAG_BITS-1:0] ctag;
    logic hit;
    icache_pkg::mem_block_u rd_block;

    // fill side, written on the clock edge
    logic fill_en;
    logic [IDX_BITS-1:0] fill_index;
    logic [TAG_BITS-1:0] fill_tag;
    icache_pkg::mem_block_u fill_block;
    // drops all valid bits
    logic clear_all;

    modport ctrl (output index, ctag, fill_en, fill_index, fill_tag, fill_block, clear_all,
                  input hit, rd_block);
    modport array (input index, ctag, fill_en, fill_index, fill_tag, fill_block, clear_all,
                   output hit, rd_block);

endinterface

`default_nettype wire

//--- src/icache_csr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_csr_if;

    // cache enable, level
    logic enable;
    // invalidate all, one-cycle pulse
    logic invalidate;

    // event pulses from the controller, one cycle each
    logic hit_event;
    logic miss_event;

    modport csr (
        output enable, invalidate,
        input hit_event, miss_event
    );

    modport ctrl (
        input enable, invalidate,
        output hit_event, miss_event
    );

endinterface

`default_nettype wire

//--- src/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
    parameter int NUM_LINES = 32
) (
    input wire logic clock,
    input wire logic rst,
    icache_array_if.array bus
);

    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = icache_pkg::ADDR_USED - icache_pkg::OFFSET_BITS - IDX_BITS;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // one valid bit per line
    logic [NUM_LINES-1:0] valid;
    // tag and block per line
    logic [TAG_BITS-1:0] tags [NUM_LINES];
    icache_pkg::mem_block_u blocks [NUM_LINES];

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    // direct mapped, so one compare
    assign bus.hit = valid[bus.index] && (tags[bus.index] == bus.ctag);
    // block goes out even on a miss, ctrl ignores it then
    assign bus.rd_block = blocks[bus.index];

    ////////////////////////////////////////////////////////////////////////////
    // fill and clear
    ////////////////////////////////////////////////////////////////////////////

    // valid bits
    always_ff @(posedge clock) begin
        if (rst) begin
            valid <= '0;
        end else if (bus.clear_all) begin
            // clear wins over a fill in the same cycle
            valid <= '0;
        end else if (bus.fill_en) begin
            valid[bus.fill_index] <= 1'b1;
        end
    end

    // tag and data written together
    always_ff @(posedge clock) begin
        if (bus.fill_en) begin
            tags[bus.fill_index] <= bus.fill_tag;
            blocks[bus.fill_index] <= bus.fill_block;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int NUM_LINES = 32
) (
    input wire logic clock,
    input wire logic rst,

    // fetch port
    input wire logic fetch_en,
    input wire logic [icache_pkg::XLEN-1:0] fetch_addr,
    output logic fetch_valid,
    output logic [icache_pkg::XLEN-1:0] fetch_inst,

    // memory port
    output logic [icache_pkg::CMD_BITS-1:0] mem_command,
    output logic [icache_pkg::XLEN-1:0] mem_addr,
    input wire logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input wire logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    input wire icache_pkg::mem_block_u mem_data,

    icache_array_if.ctrl array,
    icache_csr_if.ctrl csr
);

    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = icache_pkg::ADDR_USED - icache_pkg::OFFSET_BITS - IDX_BITS;
    localparam int IDX_LSB = icache_pkg::OFFSET_BITS;
    localparam int TAG_LSB = icache_pkg::OFFSET_BITS + IDX_BITS;
    // picks the instruction half of a block
    localparam int HALF_BIT = icache_pkg::OFFSET_BITS - 1;

    // miss sequence
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0] state;
    logic [1:0] state_next;
    // address of the outstanding miss
    logic [icache_pkg::XLEN-1:0] req_addr;
    // tag memory gave when it took the request
    logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag_q;

    logic hit_ok;
    logic req_accept;
    logic fill_done;

    ////////////////////////////////////////////////////////////////////////////
    // lookup and hit decision
    ////////////////////////////////////////////////////////////////////////////

    assign array.index = fetch_addr[IDX_LSB +: IDX_BITS];
    assign array.ctag = fetch_addr[TAG_LSB +: TAG_BITS];

    // a hit only counts with the cache on and no miss in flight
    assign hit_ok = fetch_en && csr.enable && array.hit && (state == S_IDLE);

    // memory took the request
    assign req_accept = (state == S_REQ) && (mem_response != '0);
    // data for our request is on the bus
    assign fill_done = (state == S_WAIT) && (mem_tag == mem_tag_q);

    ////////////////////////////////////////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (fetch_en && !hit_ok) begin
                    state_next = S_REQ;
                end
            end
            S_REQ: begin
                if (req_accept) begin
                    state_next = S_WAIT;
                end
            end
            S_WAIT: begin
                if (fill_done) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
            mem_tag_q <= '0;
        end else begin
            state <= state_next;
            if (req_accept) begin
                mem_tag_q <= mem_response;
            end
        end
    end

    // latch the miss address when leaving idle
    always_ff @(posedge clock) begin
        if (state == S_IDLE && fetch_en && !hit_ok) begin
            req_addr <= fetch_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////////////////////

    // load held until memory answers with a tag
    assign mem_command = (state == S_REQ) ? icache_pkg::CMD_LOAD : icache_pkg::CMD_NONE;
    // block aligned
    assign mem_addr = {req_addr[icache_pkg::XLEN-1:IDX_LSB], {IDX_LSB{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // fill and fetch return
    ////////////////////////////////////////////////////////////////////////////

    // fill only when the cache is on
    assign array.fill_en = fill_done && csr.enable;
    assign array.fill_index = req_addr[IDX_LSB +: IDX_BITS];
    assign array.fill_tag = req_addr[TAG_LSB +: TAG_BITS];
    assign array.fill_block = mem_data;
    assign array.clear_all = csr.invalidate;

    // hit path same cycle, otherwise straight from the memory bus
    assign fetch_valid = hit_ok || fill_done;
    assign fetch_inst = hit_ok ? array.rd_block.inst[fetch_addr[HALF_BIT]]
                               : mem_data.inst[req_addr[HALF_BIT]];

    // event pulses for the counters
    assign csr.hit_event = hit_ok;
    assign csr.miss_event = req_accept;

endmodule

`default_nettype wire

//--- src/icache_csr.sv
`timescale 1ns/1ps
`default_nettype none

module icache_csr (
    input wire logic clock,
    input wire logic rst,

    // wishbone classic slave
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [3:0] wb_adr,
    input wire logic [icache_pkg::XLEN-1:0] wb_dat_w,
    input wire logic [3:0] wb_sel,
    output logic [icache_pkg::XLEN-1:0] wb_dat_r,
    output logic wb_ack,

    icache_csr_if.csr ctrl
);

    logic access;
    logic wr_ctrl;
    logic wr_hits;
    logic wr_misses;

    logic enable;
    logic invalidate;
    logic [icache_pkg::XLEN-1:0] hits;
    logic [icache_pkg::XLEN-1:0] misses;

    ////////////////////////////////////////////////////////////////////////////
    // bus decode
    ////////////////////////////////////////////////////////////////////////////

    // one access per strobe, ack blocks a second one right after
    assign access = wb_cyc && wb_stb && !wb_ack;

    assign wr_ctrl = access && wb_we && (wb_adr == icache_pkg::CSR_CTRL) && wb_sel[0];
    // any write to a counter clears it
    assign wr_hits = access && wb_we && (wb_adr == icache_pkg::CSR_HITS);
    assign wr_misses = access && wb_we && (wb_adr == icache_pkg::CSR_MISSES);

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clock) begin
        if (access) begin
            case (wb_adr)
                icache_pkg::CSR_CTRL: wb_dat_r <= {{(icache_pkg::XLEN-1){1'b0}}, enable};
                icache_pkg::CSR_HITS: wb_dat_r <= hits;
                icache_pkg::CSR_MISSES: wb_dat_r <= misses;
                default: wb_dat_r <= '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            enable <= 1'b1;
            invalidate <= 1'b0;
        end else begin
            // bit 1 never stored, only pulsed
            invalidate <= wr_ctrl && wb_dat_w[1];
            if (wr_ctrl) begin
                enable <= wb_dat_w[0];
            end
        end
    end

    assign ctrl.enable = enable;
    assign ctrl.invalidate = invalidate;

    ////////////////////////////////////////////////////////////////////////////
    // event counters
    ////////////////////////////////////////////////////////////////////////////

    // saturating, clear has priority
    always_ff @(posedge clock) begin
        if (rst || wr_hits) begin
            hits <= '0;
        end else if (ctrl.hit_event && (hits != '1)) begin
            hits <= hits + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || wr_misses) begin
            misses <= '0;
        end else if (ctrl.miss_event && (misses != '1)) begin
            misses <= misses + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int NUM_LINES = 32
) (
    input wire logic clock,
    input wire logic rst,

    // fetch port
    input wire logic fetch_en,
    input wire logic [icache_pkg::XLEN-1:0] fetch_addr,
    output logic fetch_valid,
    output logic [icache_pkg::XLEN-1:0] fetch_inst,

    // memory port, tagged request/response
    output logic [icache_pkg::CMD_BITS-1:0] mem_command,
    output logic [icache_pkg::XLEN-1:0] mem_addr,
    input wire logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input wire logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    input wire icache_pkg::mem_block_u mem_data,

    // register port
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_we,
    input wire logic [3:0] wb_adr,
    input wire logic [icache_pkg::XLEN-1:0] wb_dat_w,
    input wire logic [3:0] wb_sel,
    output logic [icache_pkg::XLEN-1:0] wb_dat_r,
    output logic wb_ack
);

    // ctrl to array
    icache_array_if #(.NUM_LINES(NUM_LINES)) array_bus ();
    // csr to ctrl
    icache_csr_if csr_bus ();

    icache_ctrl #(.NUM_LINES(NUM_LINES)) icache_ctrl_inst (
        .clock(clock),
        .rst(rst),
        .fetch_en(fetch_en),
        .fetch_addr(fetch_addr),
        .fetch_valid(fetch_valid),
        .fetch_inst(fetch_inst),
        .mem_command(mem_command),
        .mem_addr(mem_addr),
        .mem_response(mem_response),
        .mem_tag(mem_tag),
        .mem_data(mem_data),
        .array(array_bus.ctrl),
        .csr(csr_bus.ctrl)
    );

    icache_array #(.NUM_LINES(NUM_LINES)) icache_array_inst (
        .clock(clock),
        .rst(rst),
        .bus(array_bus.array)
    );

    icache_csr icache_csr_inst (
        .clock(clock),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel(wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .ctrl(csr_bus.csr)
    );

endmodule

`default_nettype wire

//--- tb/icache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module icache_assert (
    input wire logic clock,
    input wire logic rst,
    input wire logic fetch_en,
    input wire logic fetch_valid,
    input wire logic [icache_pkg::CMD_BITS-1:0] mem_command,
    input wire logic [icache_pkg::XLEN-1:0] mem_addr,
    input wire logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack
);

    // no instruction without a request
    valid_needs_en: assert property (@(posedge clock) disable iff (rst)
        fetch_valid |-> fetch_en)
        else $error("fetch_valid high without fetch_en");

    // load request held until memory gives a tag
    load_held: assert property (@(posedge clock) disable iff (rst)
        (mem_command == icache_pkg::CMD_LOAD && mem_response == '0)
        |=> (mem_command == icache_pkg::CMD_LOAD && $stable(mem_addr)))
        else $error("memory request changed before it was accepted");

    // wishbone classic ack rules
    ack_in_cycle: assert property (@(posedge clock) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside of a bus cycle");

    ack_single: assert property (@(posedge clock) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high two cycles in a row");

endmodule

bind icache_top icache_assert icache_assert_inst (
    .clock(clock),
    .rst(rst),
    .fetch_en(fetch_en),
    .fetch_valid(fetch_valid),
    .mem_command(mem_command),
    .mem_addr(mem_addr),
    .mem_response(mem_response),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack)
);

`default_nettype wire

//--- tb/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int XLEN = icache_pkg::XLEN;
    localparam int NUM_LINES = 32;
    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int CLK_PERIOD = 10;
    // sample point one ns before the rising edge
    localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 1;

    // step kinds
    localparam int K_FETCH = 0;
    localparam int K_WRITE = 1;
    localparam int K_READ = 2;

    typedef struct {
        int kind;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] exp_val;
    } step_t;

    logic clock;
    logic rst;
    logic fetch_en;
    logic [XLEN-1:0] fetch_addr;
    logic fetch_valid;
    logic [XLEN-1:0] fetch_inst;
    logic [icache_pkg::CMD_BITS-1:0] mem_command;
    logic [XLEN-1:0] mem_addr;
    logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response;
    logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag;
    icache_pkg::mem_block_u mem_data;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [3:0] wb_adr;
    logic [XLEN-1:0] wb_dat_w;
    logic [3:0] wb_sel;
    logic [XLEN-1:0] wb_dat_r;
    logic wb_ack;

    // reference model of the cache contents and counters
    logic model_valid [NUM_LINES];
    int model_tag [NUM_LINES];
    logic model_enable;
    logic [XLEN-1:0] model_hits;
    logic [XLEN-1:0] model_misses;

    integer seed = 50703;
    int tests = 0;
    int errors = 0;
    step_t steps [$];

    icache_top #(.NUM_LINES(NUM_LINES)) icache_top_inst (
        .clock(clock),
        .rst(rst),
        .fetch_en(fetch_en),
        .fetch_addr(fetch_addr),
        .fetch_valid(fetch_valid),
        .fetch_inst(fetch_inst),
        .mem_command(mem_command),
        .mem_addr(mem_addr),
        .mem_response(mem_response),
        .mem_tag(mem_tag),
        .mem_data(mem_data),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel(wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory content and reference model
    ////////////////////////////////////////////////////////////////////////////

    // low half is the address and high half the address xor a5a5
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        logic [15:0] a;
        a = addr[15:0] & 16'hFFFC;
        return {a ^ 16'hA5A5, a};
    endfunction

    task automatic predict_fetch(input logic [XLEN-1:0] addr, output bit hit);
        int idx;
        int tag;
        idx = (addr[15:0] >> icache_pkg::OFFSET_BITS) % NUM_LINES;
        tag = addr[15:0] >> (icache_pkg::OFFSET_BITS + IDX_BITS);
        hit = model_enable && model_valid[idx] && (model_tag[idx] == tag);
        if (hit) begin
            model_hits++;
        end else begin
            model_misses++;
            // a disabled cache fetches but keeps nothing
            if (model_enable) begin
                model_valid[idx] = 1'b1;
                model_tag[idx] = tag;
            end
        end
    endtask

    task automatic apply_csr_write(input logic [3:0] adr, input logic [XLEN-1:0] data);
        if (adr == icache_pkg::CSR_CTRL) begin
            model_enable = data[0];
            if (data[1]) begin
                foreach (model_valid[i]) model_valid[i] = 1'b0;
            end
        end else if (adr == icache_pkg::CSR_HITS) begin
            model_hits = '0;
        end else if (adr == icache_pkg::CSR_MISSES) begin
            model_misses = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_inst(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp_val,
                              input logic [XLEN-1:0] addr);
        tests++;
        if (got !== exp_val) begin
            errors++;
            $display("Fail at %0t: fetch %h gave %h, expected %h", $time, addr, got, exp_val);
        end else begin
            $display("ok   fetch %h gave %h", addr, got);
        end
    endtask

    task automatic check_reg(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp_val,
                             input logic [3:0] adr);
        tests++;
        if (got !== exp_val) begin
            errors++;
            $display("Fail at %0t: register %h read %h, expected %h", $time, adr, got, exp_val);
        end else begin
            $display("ok   register %h read %h", adr, got);
        end
    endtask

    task automatic check_addr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp_val,
                              input logic [XLEN-1:0] addr);
        tests++;
        if (got !== exp_val) begin
            errors++;
            $display("Fail at %0t: fetch %h requested %h, expected %h", $time, addr, got,
                     exp_val);
        end else begin
            $display("ok   fetch %h requested %h", addr, got);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_fetch(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] exp_val);
        bit exp_hit;
        bit saw_load;
        int cycles;
        logic [XLEN-1:0] got;
        predict_fetch(addr, exp_hit);
        saw_load = 1'b0;
        cycles = 0;
        @(negedge clock);
        fetch_en = 1'b1;
        fetch_addr = addr;
        #(SAMPLE_DELAY);
        // address held until fetch_valid
        while (!fetch_valid) begin
            if (mem_command == icache_pkg::CMD_LOAD && !saw_load) begin
                // memory sees the 8 byte block that holds the fetch
                check_addr(mem_addr, addr & 32'hFFFF_FFF8, addr);
                saw_load = 1'b1;
            end
            cycles++;
            @(negedge clock);
            #(SAMPLE_DELAY);
        end
        got = fetch_inst;
        if (exp_hit && (cycles != 0 || mem_command != icache_pkg::CMD_NONE)) begin
            errors++;
            $display("Error at %0t: fetch %h should hit in the same cycle", $time, addr);
        end
        if (!exp_hit && (cycles == 0 || !saw_load)) begin
            errors++;
            $display("Error at %0t: fetch %h should miss and load from memory", $time, addr);
        end
        check_inst(got, exp_val, addr);
    endtask

    // one wishbone classic cycle released after ack
    task automatic run_wb(input bit we, input logic [3:0] adr, input logic [XLEN-1:0] data,
                          output logic [XLEN-1:0] rdata);
        @(negedge clock);
        fetch_en = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        wb_sel = 4'hF;
        #(SAMPLE_DELAY);
        while (!wb_ack) begin
            @(negedge clock);
            #(SAMPLE_DELAY);
        end
        rdata = wb_dat_r;
        @(negedge clock);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_step(input int kind, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp_val);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.wdata = wdata;
        s.exp_val = exp_val;
        steps.push_back(s);
    endtask

    task automatic add_fetch(input logic [XLEN-1:0] addr);
        add_step(K_FETCH, addr, '0, word_at(addr));
    endtask

    task automatic build_table();
        // cold miss then both halves of the block hit
        add_fetch(32'h0100);
        add_fetch(32'h0104);
        add_fetch(32'h0100);
        add_fetch(32'h0238);
        add_fetch(32'h023C);
        add_fetch(32'h0238);
        // index 0 shared by tags 01 and 05
        add_fetch(32'h0500);
        add_fetch(32'h0100);
        add_fetch(32'h0504);
        add_fetch(32'h0104);
        add_step(K_READ, icache_pkg::CSR_HITS, '0, '0);
        add_step(K_READ, icache_pkg::CSR_MISSES, '0, '0);
        // invalidate all with enable left on
        add_fetch(32'h0238);
        add_step(K_WRITE, icache_pkg::CSR_CTRL, 32'h3, '0);
        add_step(K_READ, icache_pkg::CSR_CTRL, '0, 32'h1);
        add_fetch(32'h0238);
        add_fetch(32'h0104);
        add_fetch(32'h0104);
        // with the cache off every fetch goes out
        add_step(K_WRITE, icache_pkg::CSR_CTRL, 32'h0, '0);
        add_step(K_READ, icache_pkg::CSR_CTRL, '0, 32'h0);
        repeat (3) add_fetch(32'h0300);
        add_step(K_READ, icache_pkg::CSR_HITS, '0, '0);
        add_step(K_READ, icache_pkg::CSR_MISSES, '0, '0);
        add_step(K_WRITE, icache_pkg::CSR_CTRL, 32'h1, '0);
        add_fetch(32'h0300);
        add_fetch(32'h0300);
        // counter clear
        add_step(K_WRITE, icache_pkg::CSR_HITS, 32'hFFFF_FFFF, '0);
        add_step(K_WRITE, icache_pkg::CSR_MISSES, 32'hFFFF_FFFF, '0);
        add_step(K_READ, icache_pkg::CSR_HITS, '0, '0);
        add_step(K_READ, icache_pkg::CSR_MISSES, '0, '0);
        // mixed traffic in the low KiB
        repeat (10) add_fetch($random(seed) & 32'h03FC);
        add_step(K_READ, icache_pkg::CSR_HITS, '0, '0);
        add_step(K_READ, icache_pkg::CSR_MISSES, '0, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int accept_wait;
        int data_wait;
        bit armed;
        bit busy;
        logic [icache_pkg::MEM_TAG_BITS-1:0] next_tag;
        logic [icache_pkg::MEM_TAG_BITS-1:0] held_tag;
        logic [XLEN-1:0] held_addr;
        accept_wait = 0;
        data_wait = 0;
        armed = 1'b0;
        busy = 1'b0;
        next_tag = 1;
        held_tag = '0;
        held_addr = '0;
        mem_response = '0;
        mem_tag = '0;
        mem_data = '0;
        forever begin
            @(negedge clock);
            // tags are zero except in their one cycle
            mem_response = '0;
            mem_tag = '0;
            mem_data = '0;
            if (rst) begin
                armed = 1'b0;
                busy = 1'b0;
            end else if (busy) begin
                if (data_wait == 0) begin
                    mem_tag = held_tag;
                    mem_data.dword = {word_at(held_addr + 4), word_at(held_addr)};
                    busy = 1'b0;
                end else begin
                    data_wait--;
                end
            end else if (mem_command == icache_pkg::CMD_LOAD) begin
                if (!armed) begin
                    accept_wait = $unsigned($random(seed)) % 4;
                    armed = 1'b1;
                end
                if (accept_wait == 0) begin
                    mem_response = next_tag;
                    held_tag = next_tag;
                    held_addr = mem_addr;
                    // tags rotate 1 to 15 as zero means no response
                    next_tag = (next_tag == 15) ? 1 : next_tag + 1;
                    data_wait = $unsigned($random(seed)) % 8;
                    armed = 1'b0;
                    busy = 1'b1;
                end else begin
                    accept_wait--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        step_t s;
        logic [XLEN-1:0] rdata;
        logic [XLEN-1:0] exp_val;
        rst = 1'b1;
        fetch_en = 1'b0;
        fetch_addr = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        foreach (model_valid[i]) model_valid[i] = 1'b0;
        foreach (model_tag[i]) model_tag[i] = 0;
        model_enable = 1'b1;
        model_hits = '0;
        model_misses = '0;
        build_table();
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.kind)
                K_FETCH: run_fetch(s.addr, s.exp_val);
                K_WRITE: begin
                    run_wb(1'b1, s.addr[3:0], s.wdata, rdata);
                    apply_csr_write(s.addr[3:0], s.wdata);
                end
                default: begin
                    run_wb(1'b0, s.addr[3:0], '0, rdata);
                    // counters come from the model and control from the table
                    if (s.addr[3:0] == icache_pkg::CSR_HITS) begin
                        exp_val = model_hits;
                    end else if (s.addr[3:0] == icache_pkg::CSR_MISSES) begin
                        exp_val = model_misses;
                    end else begin
                        exp_val = s.exp_val;
                    end
                    check_reg(rdata, exp_val, s.addr[3:0]);
                end
            endcase
        end
        @(negedge clock);
        fetch_en = 1'b0;
        repeat (4) @(posedge clock);
        $display("%0d checks, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // 20 cycles per step plus reset and margin
    initial begin
        #1;
        repeat (16 + steps.size() * 20 + 100) @(posedge clock);
        $display("timeout: the stimulus table did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/icache_pkg.sv
src/icache_array_if.sv
src/icache_csr_if.sv
src/icache_array.sv
src/icache_ctrl.sv
src/icache_csr.sv
src/icache_top.sv
tb/icache_assert.sv
tb/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  # design, package and interfaces first
  - files:
      - src/icache_pkg.sv
      - src/icache_array_if.sv
      - src/icache_csr_if.sv
      - src/icache_array.sv
      - src/icache_ctrl.sv
      - src/icache_csr.sv
      - src/icache_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/icache_assert.sv
      - tb/icache_tb.sv
